/* Makefile */
VERILATOR ?= verilator
TOP ?= execute_tb
LOG ?= sim.log
FILELIST ?= rv_execute.f
OBJ_DIR ?= obj_dir
FAIL_MSG = Done: errors found
PASS_MSG = Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing -Wno-fatal --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)_sim
	./$(OBJ_DIR)/$(TOP)_sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hdl/address_unit.sv */
`timescale 1ns/1ns

module address_unit import rv_execute_pkg::*; (
  input agu_in_t agu_in,
  output agu_out_t agu_out
);

  xdata_t address;
  logic [3:0] be;
  logic misaligned;
  logic jump;

  always_comb begin
    if (agu_in.jal | agu_in.branch | agu_in.auipc) begin
      address = agu_in.pc + agu_in.imm;
    end else begin
      address = agu_in.a + agu_in.imm;
    end
    if (agu_in.jalr) begin
      address[0] = 1'b0;
    end
    case (agu_in.op.lsu)
      LSU_LB, LSU_LBU: begin
        be = 4'b0001 << address[1:0];
        misaligned = 1'b0;
      end
      LSU_LH, LSU_LHU: begin
        be = 4'b0011 << address[1:0];
        misaligned = address[0];
      end
      default: begin
        be = 4'b1111;
        misaligned = |address[1:0];
      end
    endcase
    jump = agu_in.jal | agu_in.jalr | (agu_in.branch & agu_in.taken);

    agu_out.address = address;
    agu_out.byteenable = (agu_in.load | agu_in.store) ? be : 4'b0000;
    agu_out.exception = 1'b0;
    agu_out.ecause = 4'd0;
    if (agu_in.load & misaligned) begin
      agu_out.exception = 1'b1;
      agu_out.ecause = 4'd4;  // load address misaligned.
    end else if (agu_in.store & misaligned) begin
      agu_out.exception = 1'b1;
      agu_out.ecause = 4'd6;  // store address misaligned.
    end else if (jump & (|address[1:0])) begin
      agu_out.exception = 1'b1;  // fetch misaligned, cause 0.
    end
  end

endmodule

/* hdl/alu.sv */
`timescale 1ns/1ns
`include "rv_execute_settings.svh"

module alu import rv_execute_pkg::*; (
  input alu_in_t alu_in,
  output xdata_t result
);

  xdata_t op_b;
  logic [$clog2(`XLEN)-1:0] shamt;

  always_comb begin
    op_b = alu_in.sel ? alu_in.b : alu_in.imm;
    shamt = op_b[$clog2(`XLEN)-1:0];  // low bits only.
    case (alu_in.op.alu)
      ALU_ADD:  result = alu_in.a + op_b;
      ALU_SUB:  result = alu_in.a - op_b;
      ALU_SLL:  result = alu_in.a << shamt;
      ALU_SLT:  result = xdata_t'($signed(alu_in.a) < $signed(op_b));
      ALU_SLTU: result = xdata_t'(alu_in.a < op_b);
      ALU_XOR:  result = alu_in.a ^ op_b;
      ALU_SRL:  result = alu_in.a >> shamt;
      ALU_SRA:  result = xdata_t'($signed(alu_in.a) >>> shamt);
      ALU_OR:   result = alu_in.a | op_b;
      ALU_AND:  result = alu_in.a & op_b;
      default:  result = '0;
    endcase
  end

endmodule

/* hdl/branch_unit.sv */
`timescale 1ns/1ns

module branch_unit import rv_execute_pkg::*; (
  input xdata_t a,
  input xdata_t b,
  input logic enable,
  input bcu_op_e bcu_op,
  output logic taken
);

  logic cond;

  always_comb begin
    case (bcu_op)
      BCU_BEQ:  cond = (a == b);
      BCU_BNE:  cond = (a != b);
      BCU_BLT:  cond = ($signed(a) < $signed(b));
      BCU_BGE:  cond = ($signed(a) >= $signed(b));
      BCU_BLTU: cond = (a < b);
      BCU_BGEU: cond = (a >= b);
      default:  cond = 1'b0;
    endcase
    taken = enable & cond;  // only for real branches.
  end

endmodule

/* hdl/divider.sv */
`timescale 1ns/1ns
`include "rv_execute_settings.svh"

module divider import rv_execute_pkg::*; (
  input logic clock,
  input logic reset,
  input logic hold,
  input div_in_t div_in,
  output div_out_t div_out
);

  localparam int CW = $clog2(`DIV_STEPS + 1);

  logic busy;
  logic ready_q;
  logic [CW-1:0] count;
  xdata_t quo;
  xdata_t rem;
  xdata_t divisor;
  xdata_t result_q;
  logic neg_q;
  logic neg_r;
  logic dz;
  logic is_rem;
  logic is_signed;
  logic a_neg;
  logic b_neg;
  logic [`XLEN:0] shifted;
  logic [`XLEN:0] diff;
  xdata_t q_fix;
  xdata_t r_fix;

  always_comb begin
    is_signed = div_in.op.div inside {DIV_DIV, DIV_REM};
    a_neg = is_signed & div_in.a[`XLEN-1];
    b_neg = is_signed & div_in.b[`XLEN-1];
    shifted = {rem, quo[`XLEN-1]};
    diff = shifted - {1'b0, divisor};  // msb set means no subtract.
    q_fix = dz ? '1 : (neg_q ? -quo : quo);
    r_fix = neg_r ? -rem : rem;  // follows the dividend sign.
    div_out.ready = ready_q;
    div_out.result = result_q;
  end

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      busy <= 1'b0;
      ready_q <= 1'b0;
      count <= '0;
    end else if (!hold) begin
      if (div_in.start) begin
        busy <= 1'b1;
        ready_q <= 1'b0;
        count <= CW'(`DIV_STEPS);
      end else if (busy) begin
        if (count != 0) begin
          count <= count - 1'b1;
        end else begin
          busy <= 1'b0;
          ready_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!hold) begin
      if (div_in.start) begin
        quo <= a_neg ? -div_in.a : div_in.a;
        rem <= '0;
        divisor <= b_neg ? -div_in.b : div_in.b;
        neg_q <= a_neg ^ b_neg;
        neg_r <= a_neg;
        dz <= (div_in.b == '0);
        is_rem <= div_in.op.div inside {DIV_REM, DIV_REMU};
      end else if (busy) begin
        if (count != 0) begin
          if (diff[`XLEN]) begin
            rem <= shifted[`XLEN-1:0];
            quo <= {quo[`XLEN-2:0], 1'b0};
          end else begin
            rem <= diff[`XLEN-1:0];
            quo <= {quo[`XLEN-2:0], 1'b1};
          end
        end else begin
          result_q <= is_rem ? r_fix : q_fix;  // sign fixup step.
        end
      end
    end
  end

endmodule

/* hdl/execute_stage.sv */
`timescale 1ns/1ns
`include "rv_execute_settings.svh"

module execute_stage import rv_execute_pkg::*; (
  input logic clock,
  input logic reset,
  input uop_t in,
  input fwd_t mem_fwd,
  input fwd_t wb_fwd,
  input logic mem_stall,
  input logic clear,
  output exec_out_t q,
  output logic stall
);

  xdata_t operand1;
  xdata_t operand2;
  alu_in_t alu_in;
  xdata_t alu_result;
  logic taken;
  agu_in_t agu_in;
  agu_out_t agu_out;
  div_in_t div_in;
  div_out_t div_out;
  logic div_started;
  logic div_wait;
  exec_out_t v;
  exec_out_t r;

  operand_forward u_forward (
    .raddr1   (in.rden1 ? in.raddr1 : '0),  // unread operands see zero.
    .raddr2   (in.rden2 ? in.raddr2 : '0),
    .rdata1   (in.rdata1),
    .rdata2   (in.rdata2),
    .mem_fwd  (mem_fwd),
    .wb_fwd   (wb_fwd),
    .operand1 (operand1),
    .operand2 (operand2)
  );

  alu u_alu (
    .alu_in (alu_in),
    .result (alu_result)
  );

  branch_unit u_branch (
    .a      (operand1),
    .b      (operand2),
    .enable (in.branch),
    .bcu_op (in.bcu_op),
    .taken  (taken)
  );

  address_unit u_agu (
    .agu_in  (agu_in),
    .agu_out (agu_out)
  );

  divider u_div (
    .clock   (clock),
    .reset   (reset),
    .hold    (mem_stall),
    .div_in  (div_in),
    .div_out (div_out)
  );

  always_comb begin
    alu_in.a = operand1;
    alu_in.b = operand2;
    alu_in.imm = in.imm;
    alu_in.sel = in.rden2;
    alu_in.op = in.op;

    agu_in.a = operand1;
    agu_in.imm = in.imm;
    agu_in.pc = in.pc;
    agu_in.auipc = in.auipc;
    agu_in.jal = in.jal;
    agu_in.jalr = in.jalr;
    agu_in.branch = in.branch;
    agu_in.taken = taken;
    agu_in.load = in.load;
    agu_in.store = in.store;
    agu_in.op = in.op;

    // wait until the divider has finished this op.
    div_wait = in.valid & in.division & ~(div_started & div_out.ready);
    div_in.start = in.valid & in.division & ~div_started & ~mem_stall & ~clear;
    div_in.a = operand1;
    div_in.b = operand2;
    div_in.op = in.op;
    stall = div_wait & ~mem_stall & ~clear;

    v.valid = in.valid;
    v.rd = in.rd;
    v.wren = in.wren;
    v.jump = in.jal | in.jalr | taken;
    v.target = agu_out.address;
    v.address = agu_out.address;
    v.byteenable = agu_out.byteenable;
    v.load = in.load;
    v.store = in.store;
    v.sdata = operand2;
    v.lsu_op = in.op.lsu;
    v.exception = agu_out.exception;
    v.ecause = agu_out.ecause;

    if (in.auipc) begin
      v.wdata = agu_out.address;
    end else if (in.lui) begin
      v.wdata = in.imm;
    end else if (in.jal | in.jalr) begin
      v.wdata = in.npc;  // link value.
    end else if (in.division) begin
      v.wdata = div_out.result;
    end else begin
      v.wdata = alu_result;
    end

    if (v.exception) begin
      if (v.load) begin
        v.load = 1'b0;
        v.wren = 1'b0;
      end else if (v.store) begin
        v.store = 1'b0;
      end else begin
        v.jump = 1'b0;
        v.wren = 1'b0;
      end
    end

    if (div_wait | clear | ~in.valid) begin
      v.valid = 1'b0;
      v.wren = 1'b0;
      v.jump = 1'b0;
      v.load = 1'b0;
      v.store = 1'b0;
      v.exception = 1'b0;
    end

    q = r;
  end

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      r <= init_exec_out;
    end else if (!mem_stall || clear) begin
      r <= v;
    end
  end

  always_ff @(posedge clock) begin
    if (reset == 0) begin
      div_started <= 1'b0;
    end else if (clear) begin
      div_started <= 1'b0;  // running division is dropped.
    end else if (!mem_stall) begin
      if (div_in.start) begin
        div_started <= 1'b1;
      end else if (div_started & div_out.ready) begin
        div_started <= 1'b0;
      end
    end
  end

endmodule

/* hdl/execute_top.sv */
`timescale 1ns/1ns

module execute_top import rv_execute_pkg::*; (
  input logic clock,
  input logic reset,
  input uop_t in,
  input fwd_t mem_fwd,
  input fwd_t wb_fwd,
  input logic mem_stall,
  input logic clear,
  output exec_out_t q,
  output logic stall,
  output logic redirect_valid,
  output xdata_t redirect_target
);

  execute_stage u_stage (
    .clock     (clock),
    .reset     (reset),
    .in        (in),
    .mem_fwd   (mem_fwd),
    .wb_fwd    (wb_fwd),
    .mem_stall (mem_stall),
    .clear     (clear),
    .q         (q),
    .stall     (stall)
  );

  assign redirect_valid = q.jump;
  assign redirect_target = q.target;

endmodule

/* hdl/operand_forward.sv */
`timescale 1ns/1ns
`include "rv_execute_settings.svh"

module operand_forward import rv_execute_pkg::*; (
  input logic [`RADDR_W-1:0] raddr1,
  input logic [`RADDR_W-1:0] raddr2,
  input xdata_t rdata1,
  input xdata_t rdata2,
  input fwd_t mem_fwd,
  input fwd_t wb_fwd,
  output xdata_t operand1,
  output xdata_t operand2
);

  function automatic xdata_t pick(input logic [`RADDR_W-1:0] addr, input xdata_t data,
                                  input fwd_t mem_w, input fwd_t wb_w);
    if (addr == '0) begin
      return '0;  // x0.
    end else if (mem_w.wren && mem_w.waddr == addr) begin
      return mem_w.wdata;  // youngest write wins.
    end else if (wb_w.wren && wb_w.waddr == addr) begin
      return wb_w.wdata;
    end
    return data;
  endfunction

  always_comb begin
    operand1 = pick(raddr1, rdata1, mem_fwd, wb_fwd);
    operand2 = pick(raddr2, rdata2, mem_fwd, wb_fwd);
  end

endmodule

/* hdl/rv_execute_pkg.sv */
`include "rv_execute_settings.svh"

package rv_execute_pkg;

  typedef logic [`XLEN-1:0] xdata_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  typedef enum logic [3:0] {
    DIV_DIV, DIV_DIVU, DIV_REM, DIV_REMU
  } div_op_e;

  // funct3 encoding, low two bits give the size.
  typedef enum logic [3:0] {
    LSU_LB = 4'd0, LSU_LH = 4'd1, LSU_LW = 4'd2, LSU_LBU = 4'd4, LSU_LHU = 4'd5
  } lsu_op_e;

  // one operation word, decoded per unit.
  typedef union packed {
    alu_op_e alu;
    div_op_e div;
    lsu_op_e lsu;
  } op_u;

  typedef enum logic [2:0] {
    BCU_BEQ, BCU_BNE, BCU_BLT, BCU_BGE, BCU_BLTU, BCU_BGEU
  } bcu_op_e;

  typedef struct packed {
    logic valid;
    xdata_t pc;
    xdata_t npc;  // pc + 4.
    xdata_t imm;
    logic rden1;
    logic rden2;
    logic [`RADDR_W-1:0] raddr1;
    logic [`RADDR_W-1:0] raddr2;
    logic [`RADDR_W-1:0] rd;
    logic wren;
    logic alu;
    logic lui;
    logic auipc;
    logic jal;
    logic jalr;
    logic branch;
    logic load;
    logic store;
    logic division;
    op_u op;
    bcu_op_e bcu_op;
    xdata_t rdata1;
    xdata_t rdata2;
  } uop_t;

  typedef struct packed {
    logic wren;
    logic [`RADDR_W-1:0] waddr;
    xdata_t wdata;
  } fwd_t;

  typedef struct packed {
    logic valid;
    logic [`RADDR_W-1:0] rd;
    logic wren;
    xdata_t wdata;
    logic jump;
    xdata_t target;
    xdata_t address;
    logic [3:0] byteenable;
    logic load;
    logic store;
    xdata_t sdata;
    lsu_op_e lsu_op;
    logic exception;
    logic [3:0] ecause;
  } exec_out_t;

  typedef struct packed {
    xdata_t a;
    xdata_t b;
    xdata_t imm;
    logic sel;  // 1 picks b, 0 picks imm.
    op_u op;
  } alu_in_t;

  typedef struct packed {
    xdata_t a;
    xdata_t imm;
    xdata_t pc;
    logic auipc;
    logic jal;
    logic jalr;
    logic branch;
    logic taken;
    logic load;
    logic store;
    op_u op;
  } agu_in_t;

  typedef struct packed {
    xdata_t address;
    logic [3:0] byteenable;
    logic exception;
    logic [3:0] ecause;
  } agu_out_t;

  typedef struct packed {
    logic start;
    xdata_t a;
    xdata_t b;
    op_u op;
  } div_in_t;

  typedef struct packed {
    logic ready;
    xdata_t result;
  } div_out_t;

  localparam exec_out_t init_exec_out = exec_out_t'(0);

endpackage

/* include/rv_execute_settings.svh */
`ifndef RV_EXECUTE_SETTINGS_SVH
`define RV_EXECUTE_SETTINGS_SVH

// data path width.
`define XLEN 32

// one divider iteration per quotient bit.
`define DIV_STEPS `XLEN

// register file address width.
`define RADDR_W 5

`endif

/* rv_execute.f */
+incdir+include
hdl/rv_execute_pkg.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/address_unit.sv
hdl/divider.sv
hdl/operand_forward.sv
hdl/execute_stage.sv
hdl/execute_top.sv
testbench/execute_tb.sv

/* testbench/execute_tb.sv */
`timescale 1ns/1ns

module execute_tb import rv_execute_pkg::*; ();

  logic clock;
  logic reset;
  uop_t in;
  fwd_t mem_fwd;
  fwd_t wb_fwd;
  logic mem_stall;
  logic clear;
  exec_out_t q;
  logic stall;
  logic redirect_valid;
  xdata_t redirect_target;

  integer seed;
  int errors;
  int timeouts;
  logic timed_out;
  logic stall_on;
  logic loaded;
  exec_out_t held;
  exec_out_t got_exp;
  exec_out_t expq[$];

  execute_top uut (
    .clock           (clock),
    .reset           (reset),
    .in              (in),
    .mem_fwd         (mem_fwd),
    .wb_fwd          (wb_fwd),
    .mem_stall       (mem_stall),
    .clear           (clear),
    .q               (q),
    .stall           (stall),
    .redirect_valid  (redirect_valid),
    .redirect_target (redirect_target)
  );

  always #20 clock = ~clock;

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  function automatic xdata_t bypass(input logic en, input logic [4:0] addr, input xdata_t data,
                                    input fwd_t m, input fwd_t w);
    if (!en || addr == 5'd0) return '0;
    if (m.wren && m.waddr == addr) return m.wdata;
    if (w.wren && w.waddr == addr) return w.wdata;
    return data;
  endfunction

  function automatic xdata_t div_ref(input div_op_e op, input xdata_t a, input xdata_t b);
    logic ovf;
    ovf = (a == 32'h80000000) && (b == 32'hffffffff);
    case (op)
      DIV_DIVU: return (b == 0) ? 32'hffffffff : a / b;
      DIV_REMU: return (b == 0) ? a : a % b;
      DIV_DIV: begin
        if (b == 0) return 32'hffffffff;
        if (ovf) return a;
        return xdata_t'($signed(a) / $signed(b));
      end
      default: begin
        if (b == 0) return a;
        if (ovf) return '0;
        return xdata_t'($signed(a) % $signed(b));
      end
    endcase
  endfunction

  function automatic exec_out_t exec_model(input uop_t u, input fwd_t m, input fwd_t w);
    exec_out_t e;
    xdata_t o1;
    xdata_t o2;
    xdata_t b;
    xdata_t alu_r;
    xdata_t addr;
    logic cond;
    logic mis;
    logic [3:0] be;
    o1 = bypass(u.rden1, u.raddr1, u.rdata1, m, w);
    o2 = bypass(u.rden2, u.raddr2, u.rdata2, m, w);
    b = u.rden2 ? o2 : u.imm;
    case (u.op.alu)
      ALU_ADD: alu_r = o1 + b;
      ALU_SUB: alu_r = o1 - b;
      ALU_SLL: alu_r = o1 << b[4:0];
      ALU_SLT: alu_r = {31'b0, $signed(o1) < $signed(b)};
      ALU_SLTU: alu_r = {31'b0, o1 < b};
      ALU_XOR: alu_r = o1 ^ b;
      ALU_SRL: alu_r = o1 >> b[4:0];
      ALU_SRA: alu_r = xdata_t'($signed(o1) >>> b[4:0]);
      ALU_OR: alu_r = o1 | b;
      default: alu_r = o1 & b;
    endcase
    case (u.bcu_op)
      BCU_BEQ: cond = o1 == o2;
      BCU_BNE: cond = o1 != o2;
      BCU_BLT: cond = $signed(o1) < $signed(o2);
      BCU_BGE: cond = $signed(o1) >= $signed(o2);
      BCU_BLTU: cond = o1 < o2;
      default: cond = o1 >= o2;
    endcase
    addr = (u.jal || u.branch || u.auipc) ? u.pc + u.imm : o1 + u.imm;
    if (u.jalr) addr[0] = 1'b0;
    case (u.op[1:0])
      2'd0: begin
        be = 4'b0001 << addr[1:0];
        mis = 1'b0;
      end
      2'd1: begin
        be = 4'b0011 << addr[1:0];
        mis = addr[0];
      end
      default: begin
        be = 4'b1111;
        mis = addr[1:0] != 0;
      end
    endcase
    e = '0;
    e.valid = u.valid;
    e.rd = u.rd;
    e.wren = u.wren;
    e.jump = u.jal || u.jalr || (u.branch && cond);
    e.target = addr;
    e.address = addr;
    e.byteenable = (u.load || u.store) ? be : 4'b0000;
    e.load = u.load;
    e.store = u.store;
    e.sdata = o2;
    e.lsu_op = u.op.lsu;
    if (u.auipc) e.wdata = addr;
    else if (u.lui) e.wdata = u.imm;
    else if (u.jal || u.jalr) e.wdata = u.pc + 4;
    else if (u.division) e.wdata = div_ref(u.op.div, o1, o2);
    else e.wdata = alu_r;
    if (u.load && mis) begin
      e.exception = 1;
      e.ecause = 4'd4;
      e.load = 0;
      e.wren = 0;
    end else if (u.store && mis) begin
      e.exception = 1;
      e.ecause = 4'd6;
      e.store = 0;
    end else if (e.jump && addr[1:0] != 0) begin
      e.exception = 1;
      e.ecause = 4'd0;
      e.jump = 0;
      e.wren = 0;
    end
    return e;
  endfunction

  function automatic uop_t random_op(input int kind);
    uop_t u;
    u = '0;
    u.valid = 1;
    u.pc = rnd() & 32'hfffffffc;
    u.npc = u.pc + 4;
    u.imm = rnd();
    if (rnd() & 1) u.imm[1:0] = 2'b00;
    u.raddr1 = 5'(rnd() & 7);
    u.raddr2 = 5'(rnd() & 7);
    u.rd = 5'(rnd());
    u.rdata1 = rnd();
    u.rdata2 = rnd();
    case (kind)
      0, 1: begin
        u.alu = 1;
        u.wren = 1;
        u.rden1 = 1;
        u.rden2 = (kind == 0);
        u.op.alu = alu_op_e'(rnd() % 10);
      end
      2: begin
        u.lui = 1;
        u.wren = 1;
      end
      3: begin
        u.auipc = 1;
        u.wren = 1;
      end
      4: begin
        u.jal = 1;
        u.wren = 1;
      end
      5: begin
        u.jalr = 1;
        u.wren = 1;
        u.rden1 = 1;
      end
      6: begin
        u.branch = 1;
        u.rden1 = 1;
        u.rden2 = 1;
        u.bcu_op = bcu_op_e'(rnd() % 6);
      end
      7: begin
        u.load = 1;
        u.wren = 1;
        u.rden1 = 1;
        case (rnd() % 5)
          0: u.op.lsu = LSU_LB;
          1: u.op.lsu = LSU_LH;
          2: u.op.lsu = LSU_LW;
          3: u.op.lsu = LSU_LBU;
          default: u.op.lsu = LSU_LHU;
        endcase
      end
      8: begin
        u.store = 1;
        u.rden1 = 1;
        u.rden2 = 1;
        u.op.lsu = lsu_op_e'(rnd() % 3);
      end
      default: begin
        u.division = 1;
        u.wren = 1;
        u.rden1 = 1;
        u.rden2 = 1;
        u.op.div = div_op_e'(rnd() & 3);
        if ((rnd() & 7) == 0) u.rdata2 = '0;
      end
    endcase
    return u;
  endfunction

  function automatic fwd_t random_fwd();
    fwd_t f;
    f.wren = rnd() & 1;
    f.waddr = 5'(rnd() & 7);
    f.wdata = rnd();
    return f;
  endfunction

  function automatic uop_t div_op(input div_op_e op, input xdata_t a, input xdata_t b);
    uop_t u;
    u = '0;
    u.valid = 1;
    u.division = 1;
    u.wren = 1;
    u.rden1 = 1;
    u.rden2 = 1;
    u.raddr1 = 5'd1;
    u.raddr2 = 5'd2;
    u.rd = 5'd3;
    u.rdata1 = a;
    u.rdata2 = b;
    u.op.div = op;
    return u;
  endfunction

  function automatic logic pick_stall();
    return stall_on && ((rnd() & 7) == 0);
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_out(input exec_out_t e);
    check("q.rd", q.rd, e.rd);
    check("q.wren", q.wren, e.wren);
    check("q.wdata", q.wdata, e.wdata);
    check("q.jump", q.jump, e.jump);
    check("q.target", q.target, e.target);
    check("q.address", q.address, e.address);
    check("q.byteenable", q.byteenable, e.byteenable);
    check("q.load", q.load, e.load);
    check("q.store", q.store, e.store);
    check("q.sdata", q.sdata, e.sdata);
    check("q.lsu_op", q.lsu_op, e.lsu_op);
    check("q.exception", q.exception, e.exception);
    check("q.ecause", q.ecause, e.ecause);
    check("redirect_valid", redirect_valid, e.jump);
    check("redirect_target", redirect_target, e.target);
  endtask

  // one op, held until the stage accepts it.
  task automatic send(input uop_t u, input fwd_t mf, input fwd_t wf, input logic clr);
    int n;
    exec_out_t e;
    if (timed_out) return;
    e = exec_model(u, mf, wf);
    @(posedge clock);
    in <= u;
    mem_fwd <= mf;
    wb_fwd <= wf;
    clear <= clr;
    mem_stall <= pick_stall();
    n = 0;
    @(negedge clock);
    while (stall || mem_stall) begin
      if (n == 200) begin
        timed_out = 1;
        timeouts++;
        $display("timeout: op was not accepted within 200 cycles at %0t", $time);
        return;
      end
      n++;
      @(posedge clock);
      mem_stall <= pick_stall();
      @(negedge clock);
    end
    if (clr) begin
      @(posedge clock);
      in <= '0;
      clear <= 0;
      mem_stall <= 0;
      @(negedge clock);
      check("q.valid after clear", q.valid, 0);
    end else if (u.valid) begin
      expq.push_back(e);
    end
  endtask

  always @(posedge clock) begin
    loaded = (reset === 1'b1) && (!mem_stall || clear);  // register takes a new value.
  end

  always @(negedge clock) begin
    if (loaded) begin
      if (q.valid) begin
        if (expq.size() == 0) begin
          errors++;
          $display("valid output appeared with no op pending at %0t", $time);
        end else begin
          got_exp = expq.pop_front();
          compare_out(got_exp);
        end
      end
      held = q;
    end else if (reset === 1'b1 && q !== held) begin
      errors++;
      $display("FAIL %0t q (held): got %h expected %h", $time, q, held);
    end
  end

  initial begin
    int n;
    seed = 32'hd0272d4e;
    clock = 0;
    reset = 0;
    in = '0;
    mem_fwd = '0;
    wb_fwd = '0;
    mem_stall = 0;
    clear = 0;
    errors = 0;
    timeouts = 0;
    timed_out = 0;
    stall_on = 0;
    loaded = 0;
    held = '0;
    repeat (3) @(posedge clock);
    reset <= 1;
    @(negedge clock);
    check("q.valid after reset", q.valid, 0);
    check("q.wren after reset", q.wren, 0);
    check("q.jump after reset", q.jump, 0);
    check("q.load after reset", q.load, 0);
    check("q.store after reset", q.store, 0);
    check("q.exception after reset", q.exception, 0);
    check("stall after reset", stall, 0);

    send(div_op(DIV_DIV, 32'h80000000, 32'hffffffff), '0, '0, 0);  // overflow.
    send(div_op(DIV_REM, 32'h80000000, 32'hffffffff), '0, '0, 0);
    send(div_op(DIV_DIV, 32'hfffffff9, 32'h0), '0, '0, 0);
    send(div_op(DIV_REMU, 32'h12345678, 32'h0), '0, '0, 0);
    send(div_op(DIV_REM, 32'hffffff9c, 32'h7), '0, '0, 0);
    send(div_op(DIV_DIVU, 32'hfffffff0, 32'h3), '0, '0, 1);  // dropped by clear.

    for (int i = 0; i < 400; i++) begin
      stall_on = (i >= 200);
      send(random_op(rnd() % 10), random_fwd(), random_fwd(), (rnd() & 15) == 0);
    end

    if (!timed_out) begin
      @(posedge clock);
      in <= '0;
      mem_stall <= 0;
      n = 0;
      while (expq.size() != 0 && n < 50) begin
        @(negedge clock);
        n++;
      end
      if (expq.size() != 0) begin
        timeouts++;
        $display("timeout: %0d results never appeared on q", expq.size());
      end
    end

    $display("check errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
